// ==== hdl/fdc_pkg.sv ====
package fdc_pkg;

	//////////////////////////////
	// Widths and base types
	localparam int sram_addr_w = 19;			// 512K x 8 SRAM

	typedef logic [sram_addr_w-1:0] sram_addr_t;
	typedef logic [7:0] byte_t;

	// Identity words, read back at 04..07
	localparam logic [15:0] mco_type    = 16'hDD55;
	localparam logic [15:0] mco_version = 16'h001A;

	//////////////////////////////
	// Host register map
	typedef enum logic [7:0] {
		ADDR_LOW      = 8'h00,				// SRAM address [7:0]
		ADDR_HIGH     = 8'h01,				// SRAM address [15:8]
		ADDR_UPPER    = 8'h02,				// SRAM address [18:16]
		SRAM_DATA     = 8'h03,				// Data port, auto-increment
		DRIVE_CONTROL = 8'h04,				// Write side of 04
		TYPE_HIGH     = 8'h05,
		VER_LOW       = 8'h06,
		VER_HIGH      = 8'h07,
		STATUS        = 8'h0F,				// Read only
		STEP_RATE     = 8'hF0,
		STEP_CMD      = 8'hFF				// Write only
	} reg_addr_e;

	// Read side of 04
	localparam reg_addr_e TYPE_LOW = DRIVE_CONTROL;

	//////////////////////////////
	// Drive control, bit 0 is density
	typedef struct packed {
		logic       side_sel;				// Bit 7
		logic       motor_en;
		logic [3:0] drive_sel;
		logic       in_use;
		logic       density;				// Bit 0
	} drive_control_s;

	// Written as a byte, decoded as fields
	typedef union packed {
		byte_t          raw;
		drive_control_s f;
	} drive_control_u;

	typedef struct packed {
		logic       dir_in;					// 1 = towards the hub
		logic [6:0] count;					// Pulses to issue
	} step_cmd_s;

	//////////////////////////////
	// Wishbone classic, 8-bit
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		byte_t adr;
		byte_t dat;
	} wb_m2s_s;

	typedef struct packed {
		logic  ack;
		byte_t dat;
	} wb_s2m_s;

	// Register file to SRAM controller
	typedef struct packed {
		logic  req;							// Single-cycle request
		logic  we;
		byte_t wdata;
	} sram_req_s;

	typedef struct packed {
		logic empty;						// Address is 0
		logic full;							// Address is all ones
	} sram_flags_s;

	typedef struct packed {
		logic  load_low;
		logic  load_high;
		logic  load_upper;
		byte_t data;
	} addr_load_s;

	// Drive status inputs
	typedef struct packed {
		logic index;
		logic track0;
		logic wrprot;
		logic rdy_dchg;
		logic dens_in;
	} fd_in_s;

endpackage

// ==== hdl/sram_ctrl.sv ====
`timescale 1ns/1ps

module sram_ctrl (
	input  logic                 CLK_MASTER,
	input  logic                 reset,
	input  fdc_pkg::addr_load_s  addr_load,		// Byte-wise address loads
	input  fdc_pkg::sram_req_s   sram_req,
	input  fdc_pkg::byte_t       sram_dq_in,		// SRAM data bus as seen
	output fdc_pkg::sram_addr_t  sram_a,
	output logic                 sram_we_n,
	output logic                 sram_oe_n,
	output fdc_pkg::sram_flags_s sram_flags,
	output logic                 done,			// Access complete
	output fdc_pkg::byte_t       rdata
);

	localparam int up_w = fdc_pkg::sram_addr_w - 16;	// Bits in the upper byte

	typedef enum logic [2:0] {
		S_IDLE,		// WE inactive, OE active
		S_OEIA,		// OE inactive, bus turns round
		S_WE_LO,	// Write strobe low
		S_WE_HI,	// Strobe back up, data still driven
		S_INC		// Write done, address bumps on exit
	} state_e;

	state_e state;
	logic   rd_done;		// Read taken last edge
	logic   rd_take;

	assign rd_take = (state == S_IDLE) && sram_req.req && !sram_req.we;
	assign done    = (state == S_INC) || rd_done;

	assign sram_flags = '{empty: (sram_a == '0), full: &sram_a};

	//////////////////////////////
	// Strobe machine
	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			state     <= S_IDLE;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b0;
			rd_done   <= 1'b0;
		end else begin
			rd_done <= rd_take;					// OE already on, one cycle
			case (state)
				S_IDLE: begin
					if (sram_req.req && sram_req.we) begin
						sram_oe_n <= 1'b1;		// Release the bus first
						state     <= S_OEIA;
					end
				end
				S_OEIA: begin
					sram_we_n <= 1'b0;
					state     <= S_WE_LO;
				end
				S_WE_LO: begin
					sram_we_n <= 1'b1;			// SRAM latches on this edge
					state     <= S_WE_HI;
				end
				S_WE_HI: begin
					state <= S_INC;
				end
				S_INC: begin
					sram_oe_n <= 1'b0;			// Back to read mode
					state     <= S_IDLE;
				end
				default: begin
					sram_we_n <= 1'b1;
					sram_oe_n <= 1'b0;
					state     <= S_IDLE;
				end
			endcase
		end
	end

	// Capture read data with the request
	always_ff @(posedge CLK_MASTER) begin
		if (rd_take) begin
			rdata <= sram_dq_in;
		end
	end

	//////////////////////////////
	// Address counter
	// Loads win over the increment and the count stops at full
	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			sram_a <= '0;
		end else if (addr_load.load_low) begin
			sram_a[7:0] <= addr_load.data;
		end else if (addr_load.load_high) begin
			sram_a[15:8] <= addr_load.data;
		end else if (addr_load.load_upper) begin
			sram_a[fdc_pkg::sram_addr_w-1:16] <= addr_load.data[up_w-1:0];
		end else if (done && !sram_flags.full) begin
			sram_a <= sram_a + fdc_pkg::sram_addr_w'(1);	// Edge where done is seen
		end
	end

	// Never drive against the SRAM outputs
	a_we_oe_excl: assert property (@(posedge CLK_MASTER) disable iff (reset)
		!(!sram_we_n && !sram_oe_n));

endmodule

// ==== hdl/step_ctrl.sv ====
`timescale 1ns/1ps

module step_ctrl #(
	parameter int tick_div = 10_000				// Clocks per 250 us tick
) (
	input  logic               CLK_MASTER,
	input  logic               reset,
	input  fdc_pkg::byte_t     step_rate,		// Low time in ticks
	input  logic               step_go,
	input  fdc_pkg::step_cmd_s step_cmd,
	input  logic               track0,			// High on track 0
	output logic               fd_step,
	output logic               fd_dir,			// 1 = towards the hub
	output logic               stepping
);

	localparam int tick_w = (tick_div > 1) ? $clog2(tick_div) : 1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LEAD,	// Dir set, waiting one tick
		ST_PULSE,	// Step high for one tick
		ST_GAP		// Step low for step_rate ticks
	} state_e;

	state_e            state;
	logic [tick_w-1:0] tick_cnt;
	logic              tick;			// Clock enable, one cycle per tick
	logic              go_ok;
	logic              at_stop;			// Outward and already home
	logic [6:0]        left;			// Pulses still to give
	fdc_pkg::byte_t    rate_cnt;
	fdc_pkg::byte_t    rate_next;

	// Commands while busy or with no count are dropped
	assign go_ok     = step_go && (state == ST_IDLE) && (step_cmd.count != 7'd0);
	assign tick      = (tick_cnt == tick_w'(tick_div - 1));
	assign at_stop   = !fd_dir && track0;
	assign rate_next = rate_cnt + 8'd1;
	assign stepping  = (state != ST_IDLE);

	//////////////////////////////
	// 250 us tick
	// Restarted on go so the lead is a whole tick
	always_ff @(posedge CLK_MASTER) begin
		if (reset || go_ok || tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + tick_w'(1);
		end
	end

	//////////////////////////////
	// Step sequencer
	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			state   <= ST_IDLE;
			fd_step <= 1'b0;
			fd_dir  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (go_ok) begin
						fd_dir <= step_cmd.dir_in;
						state  <= ST_LEAD;
					end
				end
				ST_LEAD: begin
					if (at_stop) begin
						state <= ST_IDLE;		// Nothing to do outward
					end else if (tick) begin
						fd_step <= 1'b1;
						state   <= ST_PULSE;
					end
				end
				ST_PULSE: begin
					if (tick) begin
						fd_step <= 1'b0;
						state   <= ST_GAP;
					end
				end
				ST_GAP: begin
					if (at_stop) begin
						state <= ST_IDLE;		// Reached track 0, drop the rest
					end else if (tick && (rate_next >= step_rate)) begin
						if (left == 7'd0) begin
							state <= ST_IDLE;
						end else begin
							fd_step <= 1'b1;
							state   <= ST_PULSE;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Pulse and gap counters, step-rate runs off the tick enable
	always_ff @(posedge CLK_MASTER) begin
		if (go_ok) begin
			left <= step_cmd.count;
		end else if ((state == ST_PULSE) && tick) begin
			left <= left - 7'd1;				// Counted as the pulse ends
		end
		if (state == ST_PULSE) begin
			rate_cnt <= '0;
		end else if ((state == ST_GAP) && tick) begin
			rate_cnt <= rate_next;
		end
	end

	// Direction is settled for the whole pulse
	a_dir_stable: assert property (@(posedge CLK_MASTER) disable iff (reset)
		fd_step |-> $stable(fd_dir));

	// No outward pulse starts on track 0
	a_no_step_home: assert property (@(posedge CLK_MASTER) disable iff (reset)
		$rose(fd_step) |-> (fd_dir || !$past(track0)));

endmodule

// ==== hdl/fdc_reg_file.sv ====
`timescale 1ns/1ps

module fdc_reg_file (
	input  logic                    CLK_MASTER,
	input  logic                    reset,
	input  fdc_pkg::wb_m2s_s        wb_i,
	output fdc_pkg::wb_s2m_s        wb_o,
	input  fdc_pkg::fd_in_s         fd_i,
	input  fdc_pkg::sram_addr_t     sram_addr,		// Current counter value
	input  fdc_pkg::sram_flags_s    sram_flags,
	input  logic                    sram_done,
	input  fdc_pkg::byte_t          sram_rdata,
	input  logic                    stepping,
	output fdc_pkg::addr_load_s     addr_load,
	output fdc_pkg::sram_req_s      sram_req,
	output fdc_pkg::drive_control_u drive_control,
	output fdc_pkg::byte_t          step_rate,		// Gap in 250 us ticks
	output logic                    step_go,
	output fdc_pkg::step_cmd_s      step_cmd
);

	logic           ack_q;
	fdc_pkg::byte_t dat_q;
	logic           busy;				// SRAM access in flight
	logic           start;				// New bus cycle seen
	logic           is_sram;
	fdc_pkg::byte_t rd_mux;
	logic           load_low_q;
	logic           load_high_q;
	logic           load_upper_q;
	fdc_pkg::byte_t load_data_q;

	assign wb_o = '{ack: ack_q, dat: dat_q};

	// Ack low check stops a held stb restarting the cycle
	assign start   = wb_i.cyc && wb_i.stb && !ack_q && !busy;
	assign is_sram = (wb_i.adr == fdc_pkg::SRAM_DATA);

	// Request straight off the bus, dat is held until ack
	assign sram_req = '{req: start && is_sram, we: wb_i.we, wdata: wb_i.dat};

	assign addr_load = '{
		load_low:   load_low_q,
		load_high:  load_high_q,
		load_upper: load_upper_q,
		data:       load_data_q
	};

	//////////////////////////////
	// Readback mux
	always_comb begin
		case (wb_i.adr)
			fdc_pkg::ADDR_LOW:   rd_mux = sram_addr[7:0];
			fdc_pkg::ADDR_HIGH:  rd_mux = sram_addr[15:8];
			fdc_pkg::ADDR_UPPER: rd_mux = {5'b0, sram_addr[18:16]};
			fdc_pkg::SRAM_DATA:  rd_mux = sram_rdata;
			fdc_pkg::TYPE_LOW:   rd_mux = fdc_pkg::mco_type[7:0];
			fdc_pkg::TYPE_HIGH:  rd_mux = fdc_pkg::mco_type[15:8];
			fdc_pkg::VER_LOW:    rd_mux = fdc_pkg::mco_version[7:0];
			fdc_pkg::VER_HIGH:   rd_mux = fdc_pkg::mco_version[15:8];
			fdc_pkg::STATUS: begin
				rd_mux = {fd_i.index, fd_i.track0, fd_i.wrprot, fd_i.rdy_dchg,
					fd_i.dens_in, stepping, sram_flags.empty, sram_flags.full};
			end
			fdc_pkg::STEP_RATE:  rd_mux = step_rate;
			default:             rd_mux = 8'h00;	// Unmapped and STEP_CMD
		endcase
	end

	//////////////////////////////
	// Bus control and registers
	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			ack_q         <= 1'b0;
			busy          <= 1'b0;
			step_go       <= 1'b0;
			load_low_q    <= 1'b0;
			load_high_q   <= 1'b0;
			load_upper_q  <= 1'b0;
			drive_control <= '0;				// All drive pins inactive
			step_rate     <= '0;
		end else begin
			ack_q        <= 1'b0;				// Pulses by default
			step_go      <= 1'b0;
			load_low_q   <= 1'b0;
			load_high_q  <= 1'b0;
			load_upper_q <= 1'b0;
			if (busy) begin
				if (sram_done) begin			// Ack the cycle after done
					ack_q <= 1'b1;
					busy  <= 1'b0;
				end
			end else if (start) begin
				if (is_sram) begin
					busy <= 1'b1;				// Wait on the SRAM controller
				end else begin
					ack_q <= 1'b1;
					if (wb_i.we) begin
						case (wb_i.adr)
							fdc_pkg::ADDR_LOW:      load_low_q   <= 1'b1;
							fdc_pkg::ADDR_HIGH:     load_high_q  <= 1'b1;
							fdc_pkg::ADDR_UPPER:    load_upper_q <= 1'b1;
							fdc_pkg::DRIVE_CONTROL: drive_control.raw <= wb_i.dat;
							fdc_pkg::STEP_RATE:     step_rate <= wb_i.dat;
							fdc_pkg::STEP_CMD:      step_go <= 1'b1;
							default: ;				// Read-only, ignored
						endcase
					end
				end
			end
		end
	end

	// Read data, address byte and step command capture
	always_ff @(posedge CLK_MASTER) begin
		if (busy && sram_done) begin
			dat_q <= sram_rdata;				// Valid with done
		end else if (start) begin
			dat_q <= rd_mux;
		end
		if (start) begin
			load_data_q <= wb_i.dat;
		end
		if (start && wb_i.we && (wb_i.adr == fdc_pkg::STEP_CMD)) begin
			step_cmd <= fdc_pkg::step_cmd_s'(wb_i.dat);
		end
	end

	// Slave never acks outside a master cycle
	a_ack_in_cycle: assert property (@(posedge CLK_MASTER) disable iff (reset)
		ack_q |-> (wb_i.cyc && wb_i.stb));

endmodule

// ==== hdl/fdc_top.sv ====
`timescale 1ns/1ps

module fdc_top #(
	parameter int tick_div = 10_000					// 250 us at 40 MHz
) (
	input  logic                 CLK_MASTER,
	input  logic                 reset,
	input  fdc_pkg::wb_m2s_s     wb_i,				// Host bus in
	output fdc_pkg::wb_s2m_s     wb_o,				// Host bus out
	input  fdc_pkg::fd_in_s      fd_i,				// Drive status pins
	output fdc_pkg::sram_addr_t  sram_a,
	inout  wire fdc_pkg::byte_t  sram_dq,
	output logic                 sram_we_n,
	output logic                 sram_oe_n,
	output logic                 fd_dens_out,
	output logic                 fd_in_use,
	output logic [3:0]           fd_drvsel,
	output logic                 fd_moten,
	output logic                 fd_sidesel,
	output logic                 fd_step,
	output logic                 fd_dir
);

	fdc_pkg::addr_load_s     addr_load;
	fdc_pkg::sram_req_s      sram_req;
	fdc_pkg::sram_flags_s    sram_flags;
	logic                    sram_done;
	fdc_pkg::byte_t          sram_rdata;
	fdc_pkg::drive_control_u drive_control;
	fdc_pkg::byte_t          step_rate;
	logic                    step_go;
	fdc_pkg::step_cmd_s      step_cmd;
	logic                    stepping;

	//////////////////////////////
	// SRAM data bus
	// Ours while OE is inactive, else the SRAM drives it
	assign sram_dq = sram_oe_n ? sram_req.wdata : 'z;

	//////////////////////////////
	// Drive pins, all active low
	assign fd_dens_out = ~drive_control.f.density;
	assign fd_in_use   = ~drive_control.f.in_use;
	assign fd_drvsel   = ~drive_control.f.drive_sel;
	assign fd_moten    = ~drive_control.f.motor_en;
	assign fd_sidesel  = ~drive_control.f.side_sel;

	fdc_reg_file i_reg_file (
		.CLK_MASTER    (CLK_MASTER),
		.reset         (reset),
		.wb_i          (wb_i),
		.wb_o          (wb_o),
		.fd_i          (fd_i),
		.sram_addr     (sram_a),
		.sram_flags    (sram_flags),
		.sram_done     (sram_done),
		.sram_rdata    (sram_rdata),
		.stepping      (stepping),
		.addr_load     (addr_load),
		.sram_req      (sram_req),
		.drive_control (drive_control),
		.step_rate     (step_rate),
		.step_go       (step_go),
		.step_cmd      (step_cmd)
	);

	sram_ctrl i_sram_ctrl (
		.CLK_MASTER (CLK_MASTER),
		.reset      (reset),
		.addr_load  (addr_load),
		.sram_req   (sram_req),
		.sram_dq_in (sram_dq),
		.sram_a     (sram_a),
		.sram_we_n  (sram_we_n),
		.sram_oe_n  (sram_oe_n),
		.sram_flags (sram_flags),
		.done       (sram_done),
		.rdata      (sram_rdata)
	);

	step_ctrl #(
		.tick_div (tick_div)
	) i_step_ctrl (
		.CLK_MASTER (CLK_MASTER),
		.reset      (reset),
		.step_rate  (step_rate),
		.step_go    (step_go),
		.step_cmd   (step_cmd),
		.track0     (fd_i.track0),
		.fd_step    (fd_step),
		.fd_dir     (fd_dir),
		.stepping   (stepping)
	);

endmodule

// ==== verification/tb_fdc_tasks.svh ====
task automatic check_value(input string what, input logic [31:0] got,
	input logic [31:0] exp);
	if (got !== exp) begin
		$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
		$display("Finished with errors");
		$fatal(1, "Mismatch on %s", what);
	end
endtask

task automatic next_byte(output fdc_pkg::byte_t b);
	int r;
	r = $random(seed);
	b = r[7:0];
endtask

//////////////////////////////
// Wishbone master
task automatic bus_cycle(input logic we, input fdc_pkg::byte_t adr,
	input fdc_pkg::byte_t wdat, output fdc_pkg::byte_t rdat);
	int waited;
	waited = 0;
	@(posedge CLK_MASTER);
	#10;
	wb_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
	@(negedge CLK_MASTER);								// Ack settled by mid-cycle
	while (!wb_o.ack) begin
		waited++;
		if (waited == 50) begin
			$display("No ack from the DUT within 50 cycles at address %h", adr);
			$display("Finished with errors");
			$fatal(1, "Bus timeout");
		end
		@(negedge CLK_MASTER);
	end
	rdat = wb_o.dat;									// Valid with ack
	@(posedge CLK_MASTER);
	#10;
	wb_i = '0;
endtask

task automatic wb_write(input fdc_pkg::byte_t adr, input fdc_pkg::byte_t dat);
	fdc_pkg::byte_t unused;
	bus_cycle(1'b1, adr, dat, unused);
endtask

task automatic wb_read(input fdc_pkg::byte_t adr, output fdc_pkg::byte_t dat);
	bus_cycle(1'b0, adr, 8'h00, dat);
endtask

task automatic set_address(input fdc_pkg::sram_addr_t a);
	wb_write(fdc_pkg::ADDR_LOW, a[7:0]);
	wb_write(fdc_pkg::ADDR_HIGH, a[15:8]);
	wb_write(fdc_pkg::ADDR_UPPER, {5'b0, a[18:16]});
endtask

task automatic read_address(output fdc_pkg::sram_addr_t a);
	fdc_pkg::byte_t lo, hi, up;
	wb_read(fdc_pkg::ADDR_LOW, lo);
	wb_read(fdc_pkg::ADDR_HIGH, hi);
	wb_read(fdc_pkg::ADDR_UPPER, up);
	a = {up[2:0], hi, lo};
endtask

task automatic wait_step_idle();
	fdc_pkg::byte_t st;
	int polls;
	polls = 0;
	wb_read(fdc_pkg::STATUS, st);
	while (st[2]) begin								// Stepping bit
		polls++;
		if (polls == 200) begin
			$display("The stepping bit never went low");
			$display("Finished with errors");
			$fatal(1, "Stepping hung");
		end
		wb_read(fdc_pkg::STATUS, st);
	end
endtask

//////////////////////////////
// Directed tests
task automatic reset_defaults();
	fdc_pkg::byte_t rd;
	check_value("sram_we_n", 32'(sram_we_n), 32'd1);
	check_value("sram_oe_n", 32'(sram_oe_n), 32'd0);
	check_value("fd pins", 32'({fd_sidesel, fd_moten, fd_drvsel, fd_in_use, fd_dens_out}),
		32'hFF);										// All inactive
	check_value("fd_step", 32'(fd_step), 32'd0);
	check_value("ack", 32'(wb_o.ack), 32'd0);
	wb_read(fdc_pkg::TYPE_LOW, rd);
	check_value("TYPE_LOW", 32'(rd), 32'h55);
	wb_read(fdc_pkg::TYPE_HIGH, rd);
	check_value("TYPE_HIGH", 32'(rd), 32'hDD);
	wb_read(fdc_pkg::VER_LOW, rd);
	check_value("VER_LOW", 32'(rd), 32'h1A);
	wb_read(fdc_pkg::VER_HIGH, rd);
	check_value("VER_HIGH", 32'(rd), 32'h00);
endtask

task automatic address_registers();
	fdc_pkg::byte_t lo, hi, up, rd;
	fdc_pkg::sram_addr_t a;
	next_byte(lo);
	next_byte(hi);
	next_byte(up);
	wb_write(fdc_pkg::ADDR_LOW, lo);
	wb_write(fdc_pkg::ADDR_HIGH, hi);
	wb_write(fdc_pkg::ADDR_UPPER, up);
	wb_read(fdc_pkg::ADDR_LOW, rd);
	check_value("ADDR_LOW", 32'(rd), 32'(lo));
	wb_read(fdc_pkg::ADDR_HIGH, rd);
	check_value("ADDR_HIGH", 32'(rd), 32'(hi));
	wb_read(fdc_pkg::ADDR_UPPER, rd);
	check_value("ADDR_UPPER", 32'(rd), 32'({5'b0, up[2:0]}));	// Only 3 bits stored
	set_address(19'h0);
	wb_read(fdc_pkg::STATUS, rd);
	check_value("flags at 0", 32'(rd[1:0]), 32'd2);			// Empty only
	set_address(19'h7_FFFF);
	wb_read(fdc_pkg::STATUS, rd);
	check_value("flags at top", 32'(rd[1:0]), 32'd1);		// Full only
	wb_read(fdc_pkg::SRAM_DATA, rd);						// Must not wrap
	read_address(a);
	check_value("address held at full", 32'(a), 32'h7_FFFF);
endtask

task automatic sram_write_burst();
	int r;
	int i;
	fdc_pkg::sram_addr_t a;
	r = $random(seed);
	start_addr = r[18:0] & 19'h7_FFF0;					// Room for 8 below full
	set_address(start_addr);
	for (i = 0; i < 8; i++) begin
		next_byte(burst[i]);
		wb_write(fdc_pkg::SRAM_DATA, burst[i]);
	end
	for (i = 0; i < 8; i++) begin
		a = start_addr + 19'(i);
		check_value("SRAM location written", 32'(mem.exists(a)), 32'd1);
		check_value("SRAM model byte", 32'(mem[a]), 32'(burst[i]));
	end
	read_address(a);
	check_value("address after writes", 32'(a), 32'(start_addr + 19'd8));
endtask

task automatic sram_read_burst();
	fdc_pkg::byte_t rd;
	fdc_pkg::sram_addr_t a;
	int i;
	set_address(start_addr);
	for (i = 0; i < 8; i++) begin
		wb_read(fdc_pkg::SRAM_DATA, rd);
		check_value("SRAM read data", 32'(rd), 32'(burst[i]));
	end
	read_address(a);
	check_value("address after reads", 32'(a), 32'(start_addr + 19'd8));
endtask

task automatic drive_pin_mapping();
	fdc_pkg::byte_t v;
	int i;
	for (i = 0; i < 8; i++) begin
		next_byte(v);
		wb_write(fdc_pkg::DRIVE_CONTROL, v);
		// Side, motor, select, in-use, density from bit 7 down
		check_value("fd pins", 32'({fd_sidesel, fd_moten, fd_drvsel, fd_in_use, fd_dens_out}),
			32'(v ^ 8'hFF));
	end
endtask

task automatic head_stepping();
	fdc_pkg::byte_t st;
	track = 5;
	wb_write(fdc_pkg::STEP_RATE, 8'd2);
	pulses = 0;
	wb_write(fdc_pkg::STEP_CMD, {1'b1, 7'd3});			// 3 steps inward
	check_value("fd_dir inward", 32'(fd_dir), 32'd1);
	wb_read(fdc_pkg::STATUS, st);
	check_value("stepping bit", 32'(st[2]), 32'd1);
	wait_step_idle();
	check_value("inward pulses", 32'(pulses), 32'd3);
	check_value("track after inward", 32'(track), 32'd8);
	pulses = 0;
	wb_write(fdc_pkg::STEP_CMD, {1'b0, 7'd20});			// Outward run cut short at track 0
	check_value("fd_dir outward", 32'(fd_dir), 32'd0);
	wait_step_idle();
	check_value("outward pulses", 32'(pulses), 32'd8);
	check_value("track after outward", 32'(track), 32'd0);
endtask

// ==== verification/tb_fdc_top.sv ====
`timescale 1ns/1ps

module tb_fdc_top;

	//////////////////////////////
	// Run length
	localparam int clk_period  = 100;				// ns
	localparam int acc_cycles  = 8;					// Worst bus cycle, idle edges included
	localparam int n_accesses  = 80;
	localparam int step_cycles = (3 + 20) * (2 + 1) * 4 + 16;	// Pulses x ticks x tick_div
	localparam int test_cycles = acc_cycles * n_accesses + step_cycles;
	localparam longint wd_ns   = 2 * test_cycles * clk_period;	// Twice the estimate

	logic                CLK_MASTER;
	logic                reset;
	fdc_pkg::wb_m2s_s    wb_i;
	fdc_pkg::wb_s2m_s    wb_o;
	fdc_pkg::fd_in_s     fd_i;
	fdc_pkg::sram_addr_t sram_a;
	wire fdc_pkg::byte_t sram_dq;
	logic                sram_we_n;
	logic                sram_oe_n;
	logic                fd_dens_out;
	logic                fd_in_use;
	logic [3:0]          fd_drvsel;
	logic                fd_moten;
	logic                fd_sidesel;
	logic                fd_step;
	logic                fd_dir;

	int                  seed = 32'h1908_6a7d;
	int                  track = 5;					// Head position of the drive model
	int                  pulses = 0;				// Step pulses seen
	fdc_pkg::byte_t      mem [fdc_pkg::sram_addr_t];	// SRAM contents, sparse
	fdc_pkg::byte_t      sram_rd;
	fdc_pkg::byte_t      burst [8];					// Bytes written by the burst test
	fdc_pkg::sram_addr_t start_addr;

	fdc_top #(
		.tick_div (4)
	) i_fdc_top (
		.CLK_MASTER  (CLK_MASTER),
		.reset       (reset),
		.wb_i        (wb_i),
		.wb_o        (wb_o),
		.fd_i        (fd_i),
		.sram_a      (sram_a),
		.sram_dq     (sram_dq),
		.sram_we_n   (sram_we_n),
		.sram_oe_n   (sram_oe_n),
		.fd_dens_out (fd_dens_out),
		.fd_in_use   (fd_in_use),
		.fd_drvsel   (fd_drvsel),
		.fd_moten    (fd_moten),
		.fd_sidesel  (fd_sidesel),
		.fd_step     (fd_step),
		.fd_dir      (fd_dir)
	);

	`include "tb_fdc_tasks.svh"

	// Unwritten locations, pattern over all address bits
	function automatic fdc_pkg::byte_t fill_byte(input fdc_pkg::sram_addr_t a);
		return a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]} ^ 8'hA5;
	endfunction

	//////////////////////////////
	// SRAM model
	assign sram_dq = sram_oe_n ? 'z : sram_rd;		// Drives only with OE low

	always @(sram_a or sram_oe_n) begin
		sram_rd = mem.exists(sram_a) ? mem[sram_a] : fill_byte(sram_a);
	end

	always @(posedge sram_we_n) begin
		if (!reset) begin
			mem[sram_a] = sram_dq;					// Latch on WE rising
		end
	end

	//////////////////////////////
	// Drive model
	assign fd_i = '{index: 1'b0, track0: (track == 0), wrprot: 1'b0,
		rdy_dchg: 1'b0, dens_in: 1'b0};

	always @(posedge fd_step) begin
		pulses++;
		if (fd_dir) begin
			track++;								// Towards the hub
		end else if (track > 0) begin
			track--;
		end
	end

	initial begin
		CLK_MASTER = 1'b0;
		forever #(clk_period / 2) CLK_MASTER = ~CLK_MASTER;
	end

	// Watchdog
	initial begin
		#(wd_ns);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Finished with errors");
		$fatal(1, "Run timed out");
	end

	//////////////////////////////
	// Test sequence
	initial begin
		wb_i  = '0;
		reset = 1'b1;
		repeat (3) @(posedge CLK_MASTER);
		#10 reset = 1'b0;
		reset_defaults();
		address_registers();
		sram_write_burst();
		sram_read_burst();
		drive_pin_mapping();
		head_stepping();
		repeat (2) @(posedge CLK_MASTER);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+verification
hdl/fdc_pkg.sv
hdl/sram_ctrl.sv
hdl/step_ctrl.sv
hdl/fdc_reg_file.sv
hdl/fdc_top.sv
verification/tb_fdc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then decide on the log contents
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_fdc_top -o sim_fdc \
	&& ./obj_dir/sim_fdc | tee sim.log \
	|| echo "Build or run did not complete"
grep -q "Finished with no errors" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
